// ==== all.f ====
+incdir+hdl
hdl/alu_op_pkg.sv
hdl/alu_flags_pkg.sv
hdl/cond_eval.sv
hdl/result_unit.sv
hdl/result_stage.sv
hdl/flag_gen.sv
hdl/alu_top.sv
tests/tb_clock.sv
tests/alu_tb.sv

// ==== hdl/alu_consts.svh ====
`ifndef ALU_CONSTS_SVH
`define ALU_CONSTS_SVH

// operand and result width
`define ALU_DATA_WIDTH 64

// flag vector, carry overflow adjust sign zero parity
`define ALU_FLAG_WIDTH 6

// encoded field widths
`define ALU_OP_WIDTH 4
`define ALU_COND_WIDTH 4
`define ALU_OPW_WIDTH 2
`define ALU_SRC_WIDTH 3

// slots in the registered operand sign vectors
`define ALU_SIGN_W16 0
`define ALU_SIGN_W32 1
`define ALU_SIGN_W64 2
`define ALU_SIGN_BITS 3

`endif

// ==== hdl/alu_flags_pkg.sv ====
`include "alu_consts.svh"

package alu_flags_pkg;

  // bit positions in the flag vector
  typedef enum int unsigned {
    fl_parity   = 0,
    fl_zero     = 1,
    fl_sign     = 2,
    fl_adjust   = 3,
    fl_overflow = 4,
    fl_carry    = 5
  } flag_idx_e;

  // x86 style condition codes
  typedef enum logic [`ALU_COND_WIDTH-1:0] {
    cc_z   = 4'd0,
    cc_nz  = 4'd1,
    cc_s   = 4'd2,
    cc_ns  = 4'd3,
    cc_ugt = 4'd4,
    cc_ule = 4'd5,
    cc_uge = 4'd6,
    cc_ult = 4'd7,
    cc_sgt = 4'd8,
    cc_sle = 4'd9,
    cc_sge = 4'd10,
    cc_slt = 4'd11,
    cc_o   = 4'd12,
    cc_no  = 4'd13,
    cc_p   = 4'd14,
    cc_np  = 4'd15
  } cond_e;

endpackage

// ==== hdl/alu_op_pkg.sv ====
`include "alu_consts.svh"

package alu_op_pkg;

  // operation code, as issued by the scheduler
  typedef enum logic [`ALU_OP_WIDTH-1:0] {
    op_add   = 4'd0,
    op_sub   = 4'd1,
    op_and   = 4'd2,
    op_or    = 4'd3,
    op_xor   = 4'd4,
    op_mov   = 4'd5,
    op_zxt8  = 4'd6,
    op_zxt16 = 4'd7,
    op_sxt8  = 4'd8,
    op_sxt16 = 4'd9,
    op_sxt32 = 4'd10,
    op_cmov  = 4'd11,
    op_cset  = 4'd12
  } alu_op_e;

  // operand width of the operation
  typedef enum logic [`ALU_OPW_WIDTH-1:0] {
    w16 = 2'd0,
    w32 = 2'd1,
    w64 = 2'd2
  } op_width_e;

  // which datapath block drives the result
  typedef enum logic [`ALU_SRC_WIDTH-1:0] {
    src_adder  = 3'd0,
    src_logic  = 3'd1,
    src_move   = 3'd2,
    src_extend = 3'd3,
    src_cmov   = 3'd4,
    src_cset   = 3'd5
  } res_src_e;

endpackage

// ==== hdl/alu_top.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_top (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        data_en,
  input  alu_op_pkg::alu_op_e         op,
  input  alu_op_pkg::op_width_e       width,
  input  alu_flags_pkg::cond_e        cond,
  input  logic                        set_flags,
  input  logic [`ALU_DATA_WIDTH-1:0]  a,
  input  logic [`ALU_DATA_WIDTH-1:0]  b,
  input  logic [`ALU_FLAG_WIDTH-1:0]  flags_in,
  input  logic                        thread,
  input  logic                        except,
  input  logic                        except_thread,
  output logic                        ret_en,
  output logic [`ALU_DATA_WIDTH-1:0]  ret_result,
  output logic [`ALU_FLAG_WIDTH-1:0]  ret_flags,
  output logic                        ret_sets_flags
);

  logic                        take;
  logic [`ALU_DATA_WIDTH-1:0]  result;
  logic                        carry4;
  logic                        carry16;
  logic                        carry32;
  logic                        carry64;

  alu_op_pkg::alu_op_e         r_op;
  alu_op_pkg::op_width_e       r_width;
  logic                        r_set_flags;
  logic                        r_carry4;
  logic                        r_carry16;
  logic                        r_carry32;
  logic                        r_carry64;
  logic [`ALU_SIGN_BITS-1:0]   r_sign_a;
  logic [`ALU_SIGN_BITS-1:0]   r_sign_b;

  cond_eval cond_eval0 (
    .flags_in (flags_in),
    .cond     (cond),
    .take     (take)
  );

  result_unit result_unit0 (
    .op      (op),
    .width   (width),
    .take    (take),
    .a       (a),
    .b       (b),
    .result  (result),
    .carry4  (carry4),
    .carry16 (carry16),
    .carry32 (carry32),
    .carry64 (carry64)
  );

  // result register doubles as the return bus
  result_stage result_stage0 (
    .clk           (clk),
    .rst           (rst),
    .data_en       (data_en),
    .op            (op),
    .width         (width),
    .set_flags     (set_flags),
    .thread        (thread),
    .except        (except),
    .except_thread (except_thread),
    .a             (a),
    .b             (b),
    .result        (result),
    .carry4        (carry4),
    .carry16       (carry16),
    .carry32       (carry32),
    .carry64       (carry64),
    .r_op          (r_op),
    .r_width       (r_width),
    .r_set_flags   (r_set_flags),
    .r_result      (ret_result),
    .r_carry4      (r_carry4),
    .r_carry16     (r_carry16),
    .r_carry32     (r_carry32),
    .r_carry64     (r_carry64),
    .r_sign_a      (r_sign_a),
    .r_sign_b      (r_sign_b),
    .ret_en        (ret_en)
  );

  flag_gen flag_gen0 (
    .r_op           (r_op),
    .r_width        (r_width),
    .r_set_flags    (r_set_flags),
    .r_result       (ret_result),
    .r_carry4       (r_carry4),
    .r_carry16      (r_carry16),
    .r_carry32      (r_carry32),
    .r_carry64      (r_carry64),
    .r_sign_a       (r_sign_a),
    .r_sign_b       (r_sign_b),
    .ret_flags      (ret_flags),
    .ret_sets_flags (ret_sets_flags)
  );

endmodule

// ==== hdl/cond_eval.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module cond_eval (
  input  logic [`ALU_FLAG_WIDTH-1:0] flags_in,
  input  alu_flags_pkg::cond_e       cond,
  output logic                       take
);
  import alu_flags_pkg::*;

  logic cf;
  logic of;
  logic sf;
  logic zf;
  logic pf;
  logic lt; // signed less than

  assign cf = flags_in[fl_carry];
  assign of = flags_in[fl_overflow];
  assign sf = flags_in[fl_sign];
  assign zf = flags_in[fl_zero];
  assign pf = flags_in[fl_parity];
  assign lt = sf ^ of;

  always_comb begin
    take = 1'b0;
    case (cond)
      cc_z:   take = zf;
      cc_nz:  take = ~zf;
      cc_s:   take = sf;
      cc_ns:  take = ~sf;
      cc_ugt: take = ~(cf | zf);
      cc_ule: take = cf | zf;
      cc_uge: take = ~cf;
      cc_ult: take = cf;
      cc_sgt: take = ~(lt | zf);
      cc_sle: take = lt | zf;
      cc_sge: take = ~lt;
      cc_slt: take = lt;
      cc_o:   take = of;
      cc_no:  take = ~of;
      cc_p:   take = pf;
      cc_np:  take = ~pf;
    endcase
  end

endmodule

// ==== hdl/flag_gen.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module flag_gen (
  input  alu_op_pkg::alu_op_e         r_op,
  input  alu_op_pkg::op_width_e       r_width,
  input  logic                        r_set_flags,
  input  logic [`ALU_DATA_WIDTH-1:0]  r_result,
  input  logic                        r_carry4,
  input  logic                        r_carry16,
  input  logic                        r_carry32,
  input  logic                        r_carry64,
  input  logic [`ALU_SIGN_BITS-1:0]   r_sign_a,
  input  logic [`ALU_SIGN_BITS-1:0]   r_sign_b,
  output logic [`ALU_FLAG_WIDTH-1:0]  ret_flags,
  output logic                        ret_sets_flags
);
  import alu_op_pkg::*;
  import alu_flags_pkg::*;

  logic is_sub;
  logic is_arith;
  logic is_logic;
  logic carry_w;  // carry tap at the op width
  logic sign_a;
  logic sign_b;
  logic sign_r;
  logic zero_r;
  logic ovf;
  logic [`ALU_FLAG_WIDTH-1:0] flags;

  assign is_sub   = (r_op == op_sub);
  assign is_arith = (r_op == op_add) || is_sub;
  assign is_logic = (r_op == op_and) || (r_op == op_or) || (r_op == op_xor);

  always_comb begin
    case (r_width)
      w16: begin
        carry_w = r_carry16;
        sign_a  = r_sign_a[`ALU_SIGN_W16];
        sign_b  = r_sign_b[`ALU_SIGN_W16];
        sign_r  = r_result[15];
        zero_r  = (r_result[15:0] == 16'd0);
      end
      w32: begin
        carry_w = r_carry32;
        sign_a  = r_sign_a[`ALU_SIGN_W32];
        sign_b  = r_sign_b[`ALU_SIGN_W32];
        sign_r  = r_result[31];
        zero_r  = (r_result[31:0] == 32'd0);
      end
      default: begin
        carry_w = r_carry64;
        sign_a  = r_sign_a[`ALU_SIGN_W64];
        sign_b  = r_sign_b[`ALU_SIGN_W64];
        sign_r  = r_result[`ALU_DATA_WIDTH-1];
        zero_r  = (r_result == '0);
      end
    endcase
  end

  // subtract overflows when signs differ and result leaves a's sign
  assign ovf = is_sub ? ((sign_a != sign_b) && (sign_r != sign_a)) :
                        ((sign_a == sign_b) && (sign_r != sign_a));

  always_comb begin
    flags                = '0;
    flags[fl_sign]       = sign_r;
    flags[fl_zero]       = zero_r;
    flags[fl_parity]     = ~^r_result[7:0];
    if (is_arith) begin
      flags[fl_carry]    = carry_w ^ is_sub; // borrow on subtract
      flags[fl_adjust]   = r_carry4 ^ is_sub;
      flags[fl_overflow] = ovf;
    end
  end

  assign ret_sets_flags = r_set_flags && (is_arith || is_logic);
  assign ret_flags      = ret_sets_flags ? flags : '0;

endmodule

// ==== hdl/result_stage.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module result_stage (
  input  logic                        clk,
  input  logic                        rst,
  input  logic                        data_en,
  input  alu_op_pkg::alu_op_e         op,
  input  alu_op_pkg::op_width_e       width,
  input  logic                        set_flags,
  input  logic                        thread,
  input  logic                        except,
  input  logic                        except_thread,
  input  logic [`ALU_DATA_WIDTH-1:0]  a,
  input  logic [`ALU_DATA_WIDTH-1:0]  b,
  input  logic [`ALU_DATA_WIDTH-1:0]  result,
  input  logic                        carry4,
  input  logic                        carry16,
  input  logic                        carry32,
  input  logic                        carry64,
  output alu_op_pkg::alu_op_e         r_op,
  output alu_op_pkg::op_width_e       r_width,
  output logic                        r_set_flags,
  output logic [`ALU_DATA_WIDTH-1:0]  r_result,
  output logic                        r_carry4,
  output logic                        r_carry16,
  output logic                        r_carry32,
  output logic                        r_carry64,
  output logic [`ALU_SIGN_BITS-1:0]   r_sign_a,
  output logic [`ALU_SIGN_BITS-1:0]   r_sign_b,
  output logic                        ret_en
);
  import alu_op_pkg::*;

  logic except_q;
  logic except_thread_q;
  logic inhibit;

  // exception now or one edge ago on this thread
  assign inhibit = (except && (except_thread == thread)) ||
                   (except_q && (except_thread_q == thread));

  always_ff @(posedge clk) begin
    if (rst) begin
      ret_en          <= 1'b0;
      r_set_flags     <= 1'b0;
      r_op            <= op_add;
      r_width         <= w64;
      except_q        <= 1'b0;
      except_thread_q <= 1'b0;
    end else begin
      ret_en          <= data_en & ~inhibit;
      r_set_flags     <= set_flags & data_en;
      r_op            <= op;
      r_width         <= width;
      except_q        <= except;
      except_thread_q <= except_thread;
    end
  end

  always_ff @(posedge clk) begin
    r_result  <= result;
    r_carry4  <= carry4;
    r_carry16 <= carry16;
    r_carry32 <= carry32;
    r_carry64 <= carry64;
    r_sign_a[`ALU_SIGN_W16] <= a[15];
    r_sign_a[`ALU_SIGN_W32] <= a[31];
    r_sign_a[`ALU_SIGN_W64] <= a[`ALU_DATA_WIDTH-1];
    r_sign_b[`ALU_SIGN_W16] <= b[15];
    r_sign_b[`ALU_SIGN_W32] <= b[31];
    r_sign_b[`ALU_SIGN_W64] <= b[`ALU_DATA_WIDTH-1];
  end

endmodule

// ==== hdl/result_unit.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module result_unit (
  input  alu_op_pkg::alu_op_e         op,
  input  alu_op_pkg::op_width_e       width,
  input  logic                        take,
  input  logic [`ALU_DATA_WIDTH-1:0]  a,
  input  logic [`ALU_DATA_WIDTH-1:0]  b,
  output logic [`ALU_DATA_WIDTH-1:0]  result,
  output logic                        carry4,
  output logic                        carry16,
  output logic                        carry32,
  output logic                        carry64
);
  import alu_op_pkg::*;

  localparam int DW = `ALU_DATA_WIDTH;

  logic          sub;
  logic [DW-1:0] b_add;
  logic [DW:0]   sum;
  logic [DW-1:0] carry_in; // carry into each bit position

  res_src_e      src;
  logic [DW-1:0] logic_val;
  logic [DW-1:0] ext_val;
  logic [DW-1:0] raw;

  // subtract as a + ~b + 1
  assign sub   = (op == op_sub);
  assign b_add = sub ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_add} + {{DW{1'b0}}, sub};

  assign carry_in = a ^ b_add ^ sum[DW-1:0];

  assign carry4  = carry_in[4];  // out of bit 3
  assign carry16 = carry_in[16];
  assign carry32 = carry_in[32];
  assign carry64 = sum[DW];

  always_comb begin
    src = src_logic;
    case (op)
      op_add, op_sub:           src = src_adder;
      op_and, op_or, op_xor:    src = src_logic;
      op_mov:                   src = src_move;
      op_zxt8, op_zxt16:        src = src_extend;
      op_sxt8, op_sxt16,
      op_sxt32:                 src = src_extend;
      op_cmov:                  src = src_cmov;
      op_cset:                  src = src_cset;
      default:                  src = src_logic;
    endcase
  end

  always_comb begin
    case (op)
      op_or:   logic_val = a | b;
      op_xor:  logic_val = a ^ b;
      default: logic_val = a & b;
    endcase
  end

  // extension source is always b
  always_comb begin
    case (op)
      op_zxt8:  ext_val = {{(DW-8){1'b0}}, b[7:0]};
      op_zxt16: ext_val = {{(DW-16){1'b0}}, b[15:0]};
      op_sxt8:  ext_val = {{(DW-8){b[7]}}, b[7:0]};
      op_sxt16: ext_val = {{(DW-16){b[15]}}, b[15:0]};
      default:  ext_val = {{(DW-32){b[31]}}, b[31:0]};
    endcase
  end

  always_comb begin
    case (src)
      src_adder:  raw = sum[DW-1:0];
      src_logic:  raw = logic_val;
      src_move:   raw = b;
      src_extend: raw = ext_val;
      src_cmov:   raw = take ? b : a;
      src_cset:   raw = {{(DW-1){1'b0}}, take};
      default:    raw = logic_val;
    endcase
  end

  // width shaping, extensions produce a full register
  always_comb begin
    if (src == src_extend) begin
      result = raw;
    end else begin
      case (width)
        w16:     result = {a[DW-1:16], raw[15:0]}; // merge into a
        w32:     result = {{(DW-32){1'b0}}, raw[31:0]};
        default: result = raw;
      endcase
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module alu_tb -f all.f -o alu_sim
./obj_dir/alu_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation reported failures"
  exit 1
fi
echo "simulation finished without failures"

// ==== tests/alu_tb.sv ====
`timescale 1ns/1ps
`include "alu_consts.svh"

module alu_tb;
  import alu_op_pkg::*;
  import alu_flags_pkg::*;

  localparam int DW      = `ALU_DATA_WIDTH;
  localparam int FW      = `ALU_FLAG_WIDTH;
  localparam int PERIOD  = 40;
  localparam int NUM_OPS = 3*2*(9*9 + 16) + 3*4*8 + 5*8 + 2*16*4 + 32 + 4 + 32;

  logic          clk;
  logic          rst;
  logic          data_en;
  alu_op_e       op;
  op_width_e     width;
  cond_e         cond;
  logic          set_flags;
  logic [DW-1:0] a;
  logic [DW-1:0] b;
  logic [FW-1:0] flags_in;
  logic          thread;
  logic          except;
  logic          except_thread;
  logic          ret_en;
  logic [DW-1:0] ret_result;
  logic [FW-1:0] ret_flags;
  logic          ret_sets_flags;

  // one-deep model queue, filled at the issue edge
  logic          exp_en;
  logic          exp_sets;
  logic [DW-1:0] exp_result;
  logic [FW-1:0] exp_flags;
  logic          prev_exc;
  logic          prev_exc_thread;
  logic [DW-1:0] edge_vals [9];
  int            err_en = 0;
  int            err_result = 0;
  int            err_flags = 0;
  int            err_sets = 0;

  tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(3)) clock0 (.clk(clk), .rst(rst));

  alu_top dut0 (
    .clk(clk), .rst(rst), .data_en(data_en), .op(op), .width(width), .cond(cond),
    .set_flags(set_flags), .a(a), .b(b), .flags_in(flags_in), .thread(thread),
    .except(except), .except_thread(except_thread), .ret_en(ret_en),
    .ret_result(ret_result), .ret_flags(ret_flags), .ret_sets_flags(ret_sets_flags)
  );

  // x86 encoding, even code is the true form, odd code its inverse
  function automatic logic cond_taken(input cond_e c, input logic [FW-1:0] f);
    logic lt;
    logic v;
    lt = f[fl_sign] ^ f[fl_overflow];
    case (c[3:1])
      3'd0:    v = f[fl_zero];
      3'd1:    v = f[fl_sign];
      3'd2:    v = ~(f[fl_carry] | f[fl_zero]);
      3'd3:    v = ~f[fl_carry];
      3'd4:    v = ~(lt | f[fl_zero]);
      3'd5:    v = ~lt;
      3'd6:    v = f[fl_overflow];
      default: v = f[fl_parity];
    endcase
    return v ^ c[0];
  endfunction

  function automatic logic [DW-1:0] result_for(input alu_op_e o, input op_width_e w,
                                               input logic tk, input logic [DW-1:0] x,
                                               input logic [DW-1:0] y);
    logic [DW-1:0] v;
    case (o)
      op_zxt8:  return {56'd0, y[7:0]};
      op_zxt16: return {48'd0, y[15:0]};
      op_sxt8:  return {{56{y[7]}}, y[7:0]};
      op_sxt16: return {{48{y[15]}}, y[15:0]};
      op_sxt32: return {{32{y[31]}}, y[31:0]};
      op_add:   v = x + y;
      op_sub:   v = x - y;
      op_and:   v = x & y;
      op_or:    v = x | y;
      op_xor:   v = x ^ y;
      op_cmov:  v = tk ? y : x;
      op_cset:  v = {63'd0, tk};
      default:  v = y; // mov
    endcase
    case (w)
      w16:     return {x[63:16], v[15:0]};
      w32:     return {32'd0, v[31:0]};
      default: return v;
    endcase
  endfunction

  function automatic logic [FW-1:0] flags_for(input alu_op_e o, input op_width_e w,
                                              input logic [DW-1:0] x, input logic [DW-1:0] y,
                                              input logic [DW-1:0] r);
    int          n;
    logic [DW:0] mask;
    logic [DW:0] wide;
    logic [FW-1:0] f;
    n = (w == w16) ? 16 : ((w == w32) ? 32 : 64);
    mask = (65'd1 << n) - 65'd1;
    wide = (65'(x) & mask) + (65'(y) & mask);
    f = '0;
    f[fl_sign]   = r[n-1];
    f[fl_zero]   = ((65'(r) & mask) == 65'd0);
    f[fl_parity] = ~^r[7:0];
    if (o == op_add) begin
      f[fl_carry]    = wide[n];
      f[fl_adjust]   = (5'(x[3:0]) + 5'(y[3:0])) > 5'd15;
      f[fl_overflow] = (x[n-1] == y[n-1]) && (r[n-1] != x[n-1]);
    end else if (o == op_sub) begin
      f[fl_carry]    = (65'(x) & mask) < (65'(y) & mask); // borrow
      f[fl_adjust]   = x[3:0] < y[3:0];
      f[fl_overflow] = (x[n-1] != y[n-1]) && (r[n-1] != x[n-1]);
    end
    return f;
  endfunction

  function automatic logic is_flag_op(input alu_op_e o);
    return (o == op_add) || (o == op_sub) || (o == op_and) || (o == op_or) || (o == op_xor);
  endfunction

  always @(posedge clk) begin
    if (rst) begin
      exp_en          <= 1'b0;
      exp_sets        <= 1'b0;
      prev_exc        <= 1'b0;
      prev_exc_thread <= 1'b0;
    end else begin
      exp_en <= data_en && !(except && (except_thread == thread)) &&
                !(prev_exc && (prev_exc_thread == thread));
      exp_sets   <= data_en && set_flags && is_flag_op(op);
      exp_result <= result_for(op, width, cond_taken(cond, flags_in), a, b);
      exp_flags  <= (set_flags && is_flag_op(op)) ?
                    flags_for(op, width, a, b, result_for(op, width, 1'b0, a, b)) : '0;
      prev_exc        <= except;
      prev_exc_thread <= except_thread;
    end
  end

  assert property (@(posedge clk) disable iff (rst) ret_en == exp_en)
    else begin
      err_en++;
      $display("mismatch at %0t: ret_en got %b expected %b", $time,
               $sampled(ret_en), $sampled(exp_en));
    end

  assert property (@(posedge clk) disable iff (rst) exp_en |-> ret_result == exp_result)
    else begin
      err_result++;
      $display("mismatch at %0t: ret_result got %h expected %h", $time,
               $sampled(ret_result), $sampled(exp_result));
    end

  assert property (@(posedge clk) disable iff (rst) exp_en |-> ret_flags == exp_flags)
    else begin
      err_flags++;
      $display("mismatch at %0t: ret_flags got %b expected %b", $time,
               $sampled(ret_flags), $sampled(exp_flags));
    end

  assert property (@(posedge clk) disable iff (rst) exp_en |-> ret_sets_flags == exp_sets)
    else begin
      err_sets++;
      $display("mismatch at %0t: ret_sets_flags got %b expected %b", $time,
               $sampled(ret_sets_flags), $sampled(exp_sets));
    end

  function automatic logic [DW-1:0] rnd64();
    return {$urandom, $urandom};
  endfunction

  task automatic drive_op(input alu_op_e o, input op_width_e w, input cond_e c,
                          input logic [DW-1:0] x, input logic [DW-1:0] y,
                          input logic [FW-1:0] f, input logic sf, input logic thr,
                          input logic exc, input logic exc_thr);
    @(posedge clk);
    data_en       <= 1'b1;
    op            <= o;
    width         <= w;
    cond          <= c;
    a             <= x;
    b             <= y;
    flags_in      <= f;
    set_flags     <= sf;
    thread        <= thr;
    except        <= exc;
    except_thread <= exc_thr;
  endtask

  task automatic issue(input alu_op_e o, input op_width_e w, input cond_e c,
                       input logic [DW-1:0] x, input logic [DW-1:0] y);
    drive_op(o, w, c, x, y, 6'($urandom), 1'b1, 1'b0, 1'b0, 1'b0);
  endtask

  task automatic idle(input logic exc, input logic exc_thr);
    @(posedge clk);
    data_en       <= 1'b0;
    except        <= exc;
    except_thread <= exc_thr;
  endtask

  initial begin
    void'($urandom(32'hf1f8));
    data_en = 1'b0;
    op = op_add;
    width = w64;
    cond = cc_z;
    set_flags = 1'b0;
    a = '0;
    b = '0;
    flags_in = '0;
    thread = 1'b0;
    except = 1'b0;
    except_thread = 1'b0;
    edge_vals = '{64'h0, 64'h1, 64'hffff_ffff_ffff_ffff, 64'h7fff_ffff_ffff_ffff,
                  64'h8000_0000_0000_0000, 64'h7fff_ffff, 64'h8000_0000, 64'h7fff, 64'h8000};
    while (rst) @(posedge clk);
    idle(1'b0, 1'b0);
    idle(1'b0, 1'b0);
    for (int w = 0; w < 3; w++) begin
      for (int s = 0; s < 2; s++) begin // add then sub
        for (int i = 0; i < 9; i++) begin
          for (int j = 0; j < 9; j++) begin
            issue(alu_op_e'(4'(s)), op_width_e'(2'(w)), cc_z, edge_vals[i], edge_vals[j]);
          end
        end
        repeat (16) issue(alu_op_e'(4'(s)), op_width_e'(2'(w)), cc_z, rnd64(), rnd64());
      end
    end
    for (int w = 0; w < 3; w++) begin
      for (int k = 0; k < 4; k++) begin // and, or, xor, mov
        repeat (8) issue(alu_op_e'(4'(2 + k)), op_width_e'(2'(w)), cc_z, rnd64(), rnd64());
      end
    end
    for (int k = 0; k < 5; k++) begin
      repeat (8) issue(alu_op_e'(4'(6 + k)), op_width_e'(2'($urandom_range(0, 2))), cc_z,
                       rnd64(), rnd64());
    end
    for (int c = 0; c < 16; c++) begin
      repeat (4) issue(op_cmov, w64, cond_e'(4'(c)), rnd64(), rnd64());
      repeat (4) issue(op_cset, op_width_e'(2'($urandom_range(0, 2))), cond_e'(4'(c)),
                       rnd64(), rnd64());
    end
    repeat (32) begin
      drive_op(alu_op_e'(4'($urandom_range(0, 12))), op_width_e'(2'($urandom_range(0, 2))),
               cond_e'(4'($urandom)), rnd64(), rnd64(), 6'($urandom), 1'($urandom),
               1'($urandom), 1'b0, 1'b0);
    end
    idle(1'b1, 1'b1); // pulse on thread 1 with no issue
    drive_op(op_add, w64, cc_z, rnd64(), rnd64(), 6'd0, 1'b1, 1'b1, 1'b0, 1'b0);
    drive_op(op_add, w32, cc_z, rnd64(), rnd64(), 6'd0, 1'b1, 1'b0, 1'b1, 1'b0);
    drive_op(op_sub, w16, cc_z, rnd64(), rnd64(), 6'd0, 1'b1, 1'b0, 1'b0, 1'b0);
    drive_op(op_xor, w64, cc_z, rnd64(), rnd64(), 6'd0, 1'b1, 1'b1, 1'b1, 1'b0);
    repeat (32) begin
      drive_op(alu_op_e'(4'($urandom_range(0, 4))), w64, cc_z, rnd64(), rnd64(),
               6'($urandom), 1'b1, 1'($urandom), $urandom_range(0, 3) == 0, 1'($urandom));
    end
    repeat (4) idle(1'b0, 1'b0);
    $display("errors: ret_en %0d, ret_result %0d, ret_flags %0d, ret_sets_flags %0d",
             err_en, err_result, err_flags, err_sets);
    if (err_en + err_result + err_flags + err_sets == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

  initial begin
    #((NUM_OPS + 20) * PERIOD);
    $display("timeout: the run did not finish within %0d cycles", NUM_OPS + 20);
    $display("Test failures found");
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD       = 40,
  parameter int RESET_CYCLES = 3
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD / 2) clk = ~clk;
  end

  // reset released on the edge after the last reset cycle
  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule
